// ==== Bender.yml ====
package:
  name: align_ecc_1rw

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/align_ecc_pkg.sv
      - design/ecc_secded_enc.sv
      - design/ecc_cmd_stage.sv
      - design/sram_1rw_model.sv
      - design/ecc_read_stage.sv
      - design/align_ecc_1rw_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - tb/tb_align_ecc_1rw.sv

// ==== design/align_ecc_1rw_top.sv ====
`timescale 1ns/100ps

module align_ecc_1rw_top
  import align_ecc_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  logic  write,
  input  addr_t wr_adr,
  input  data_t din,
  input  code_t wr_flip,
  input  logic  read,
  input  addr_t rd_adr,
  output logic  rd_vld,
  output data_t rd_dout,
  output logic  rd_serr,
  output logic  rd_derr,
  output padr_t rd_padr
);

  logic      mem_write;
  logic      mem_read;
  srow_t     mem_addr;
  row_t      mem_bw;
  row_t      mem_din;
  row_t      mem_dout;
  logic      tag_vld;
  word_sel_t tag_word;
  srow_t     tag_srow;

  ecc_cmd_stage u_ecc_cmd_stage (
    .clk       (clk),
    .rst       (rst),
    .write     (write),
    .wr_adr    (wr_adr),
    .din       (din),
    .wr_flip   (wr_flip),
    .read      (read),
    .rd_adr    (rd_adr),
    .mem_write (mem_write),
    .mem_read  (mem_read),
    .mem_addr  (mem_addr),
    .mem_bw    (mem_bw),
    .mem_din   (mem_din),
    .tag_vld   (tag_vld),
    .tag_word  (tag_word),
    .tag_srow  (tag_srow)
  );

  sram_1rw_model u_sram_1rw_model (
    .clk       (clk),
    .mem_write (mem_write),
    .mem_read  (mem_read),
    .mem_addr  (mem_addr),
    .mem_bw    (mem_bw),
    .mem_din   (mem_din),
    .mem_dout  (mem_dout)
  );

  ecc_read_stage u_ecc_read_stage (
    .clk      (clk),
    .rst      (rst),
    .tag_vld  (tag_vld),
    .tag_word (tag_word),
    .tag_srow (tag_srow),
    .mem_dout (mem_dout),
    .rd_vld   (rd_vld),
    .rd_dout  (rd_dout),
    .rd_serr  (rd_serr),
    .rd_derr  (rd_derr),
    .rd_padr  (rd_padr)
  );

endmodule

// ==== design/align_ecc_params.svh ====
`ifndef ALIGN_ECC_PARAMS_SVH
`define ALIGN_ECC_PARAMS_SVH

// data word and SECDED check bits.
`define ALIGN_WIDTH 32
`define ALIGN_ECCWDTH 7
`define ALIGN_MEMWDTH 39

// logical address space.
`define ALIGN_NUMADDR 48
`define ALIGN_BITADDR 6

// words packed into one physical row.
`define ALIGN_NUMWRDS 4
`define ALIGN_BITWRDS 2

// physical rows, not a power of two.
`define ALIGN_NUMSROW 12
`define ALIGN_BITSROW 4

// cycles from sampled read to row data.
`define ALIGN_SRAM_DELAY 2

`endif

// ==== design/align_ecc_pkg.sv ====
`include "align_ecc_params.svh"

package align_ecc_pkg;

  typedef logic [`ALIGN_BITADDR-1:0] addr_t;
  typedef logic [`ALIGN_WIDTH-1:0] data_t;
  typedef logic [`ALIGN_ECCWDTH-1:0] check_t;
  // check bits sit above the data.
  typedef logic [`ALIGN_MEMWDTH-1:0] code_t;
  typedef logic [`ALIGN_BITWRDS-1:0] word_sel_t;
  typedef logic [`ALIGN_BITSROW-1:0] srow_t;
  typedef logic [`ALIGN_NUMWRDS*`ALIGN_MEMWDTH-1:0] row_t;
  typedef logic [`ALIGN_BITWRDS+`ALIGN_BITSROW-1:0] padr_t;
  typedef logic [`ALIGN_ECCWDTH-2:0] syndrome_t;

  // syndrome of data bit idx: the idx-th position in 1..38 that is not a power of two.
  function automatic syndrome_t hamming_pos(input int unsigned idx);
    int unsigned cnt;
    syndrome_t pos;
    cnt = 0;
    pos = '0;
    for (int unsigned p = 1; p < `ALIGN_MEMWDTH; p++) begin
      if ((p & (p - 1)) != 0) begin
        if (cnt == idx) begin
          pos = syndrome_t'(p);
        end
        cnt++;
      end
    end
    return pos;
  endfunction

endpackage

// ==== design/ecc_cmd_stage.sv ====
`timescale 1ns/100ps
`include "align_ecc_params.svh"

module ecc_cmd_stage
  import align_ecc_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      write,
  input  addr_t     wr_adr,
  input  data_t     din,
  input  code_t     wr_flip,
  input  logic      read,
  input  addr_t     rd_adr,
  output logic      mem_write,
  output logic      mem_read,
  output srow_t     mem_addr,
  output row_t      mem_bw,
  output row_t      mem_din,
  output logic      tag_vld,
  output word_sel_t tag_word,
  output srow_t     tag_srow
);

  logic      wr_ok;
  logic      rd_ok;
  addr_t     cmd_adr;
  word_sel_t cmd_word;
  srow_t     cmd_srow;
  check_t    wr_check;
  code_t     wr_code;
  row_t      bw_next;

  // out of range commands are dropped.
  assign wr_ok = write && (wr_adr < `ALIGN_NUMADDR);
  // the single port goes to the write when both are valid.
  assign rd_ok = read && !wr_ok && (rd_adr < `ALIGN_NUMADDR);

  assign cmd_adr  = wr_ok ? wr_adr : rd_adr;
  assign cmd_word = word_sel_t'(cmd_adr % `ALIGN_NUMWRDS);
  assign cmd_srow = srow_t'(cmd_adr / `ALIGN_NUMWRDS);

  ecc_secded_enc u_ecc_secded_enc (
    .data  (din),
    .check (wr_check)
  );

  // injected errors land in the stored codeword.
  assign wr_code = {wr_check, din} ^ wr_flip;
  assign bw_next = row_t'({`ALIGN_MEMWDTH{1'b1}}) << (cmd_word * `ALIGN_MEMWDTH);

  always_ff @(posedge clk) begin
    if (rst) begin
      mem_write <= 1'b0;
      mem_read  <= 1'b0;
      tag_vld   <= 1'b0;
    end else begin
      mem_write <= wr_ok;
      mem_read  <= rd_ok;
      tag_vld   <= rd_ok;
    end
  end

  always_ff @(posedge clk) begin
    mem_addr <= cmd_srow;
    mem_bw   <= bw_next;
    // same codeword in every slice, the mask picks one.
    mem_din  <= {`ALIGN_NUMWRDS{wr_code}};
    tag_word <= cmd_word;
    tag_srow <= cmd_srow;
  end

endmodule

// ==== design/ecc_read_stage.sv ====
`timescale 1ns/100ps
`include "align_ecc_params.svh"

module ecc_read_stage
  import align_ecc_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      tag_vld,
  input  word_sel_t tag_word,
  input  srow_t     tag_srow,
  input  row_t      mem_dout,
  output logic      rd_vld,
  output data_t     rd_dout,
  output logic      rd_serr,
  output logic      rd_derr,
  output padr_t     rd_padr
);

  logic      vld_pipe [0:`ALIGN_SRAM_DELAY-1];
  word_sel_t word_pipe [0:`ALIGN_SRAM_DELAY-1];
  srow_t     srow_pipe [0:`ALIGN_SRAM_DELAY-1];

  word_sel_t sel_word;
  code_t     sel_code;
  data_t     sel_data;
  check_t    sel_check;
  check_t    calc_check;
  syndrome_t syndrome;
  logic      parity_err;
  data_t     fixed_data;

  // tag follows the read through the SRAM latency.
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `ALIGN_SRAM_DELAY; i++) begin
        vld_pipe[i] <= 1'b0;
      end
    end else begin
      vld_pipe[0] <= tag_vld;
      for (int i = 1; i < `ALIGN_SRAM_DELAY; i++) begin
        vld_pipe[i] <= vld_pipe[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    word_pipe[0] <= tag_word;
    srow_pipe[0] <= tag_srow;
    for (int i = 1; i < `ALIGN_SRAM_DELAY; i++) begin
      word_pipe[i] <= word_pipe[i-1];
      srow_pipe[i] <= srow_pipe[i-1];
    end
  end

  assign sel_word  = word_pipe[`ALIGN_SRAM_DELAY-1];
  assign sel_code  = mem_dout[sel_word*`ALIGN_MEMWDTH +: `ALIGN_MEMWDTH];
  assign sel_data  = sel_code[`ALIGN_WIDTH-1:0];
  assign sel_check = sel_code[`ALIGN_MEMWDTH-1:`ALIGN_WIDTH];

  ecc_secded_enc u_ecc_secded_enc (
    .data  (sel_data),
    .check (calc_check)
  );

  assign syndrome   = calc_check[`ALIGN_ECCWDTH-2:0] ^ sel_check[`ALIGN_ECCWDTH-2:0];
  assign parity_err = ^sel_code;

  // no matching data bit means the flip hit a check bit.
  always_comb begin
    fixed_data = sel_data;
    for (int i = 0; i < `ALIGN_WIDTH; i++) begin
      if (parity_err && (hamming_pos(i) == syndrome)) begin
        fixed_data[i] = ~sel_data[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_vld <= 1'b0;
    end else begin
      rd_vld <= vld_pipe[`ALIGN_SRAM_DELAY-1];
    end
  end

  always_ff @(posedge clk) begin
    rd_dout <= fixed_data;
    rd_serr <= parity_err;
    // even parity with a nonzero syndrome is two flips.
    rd_derr <= !parity_err && (syndrome != '0);
    rd_padr <= {sel_word, srow_pipe[`ALIGN_SRAM_DELAY-1]};
  end

endmodule

// ==== design/ecc_secded_enc.sv ====
`timescale 1ns/100ps
`include "align_ecc_params.svh"

module ecc_secded_enc
  import align_ecc_pkg::*;
(
  input  data_t  data,
  output check_t check
);

  syndrome_t ham;
  syndrome_t pos;

  // each data bit feeds the hamming bits set in its position.
  always_comb begin
    ham = '0;
    pos = '0;
    for (int i = 0; i < `ALIGN_WIDTH; i++) begin
      pos = hamming_pos(i);
      ham = ham ^ (pos & {($bits(syndrome_t)){data[i]}});
    end
  end

  // overall parity makes the whole codeword even.
  assign check = {(^data) ^ (^ham), ham};

endmodule

// ==== design/sram_1rw_model.sv ====
`timescale 1ns/100ps
`include "align_ecc_params.svh"

module sram_1rw_model
  import align_ecc_pkg::*;
(
  input  logic  clk,
  input  logic  mem_write,
  input  logic  mem_read,
  input  srow_t mem_addr,
  input  row_t  mem_bw,
  input  row_t  mem_din,
  output row_t  mem_dout
);

  row_t mem [0:`ALIGN_NUMSROW-1];
  row_t rd_pipe [0:`ALIGN_SRAM_DELAY-1];

  // bit mask merge keeps the other words of the row.
  always_ff @(posedge clk) begin
    if (mem_write) begin
      mem[mem_addr] <= (mem[mem_addr] & ~mem_bw) | (mem_din & mem_bw);
    end
  end

  always_ff @(posedge clk) begin
    if (mem_read) begin
      rd_pipe[0] <= mem[mem_addr];
    end
    for (int i = 1; i < `ALIGN_SRAM_DELAY; i++) begin
      rd_pipe[i] <= rd_pipe[i-1];
    end
  end

  assign mem_dout = rd_pipe[`ALIGN_SRAM_DELAY-1];

endmodule

// ==== filelist.f ====
+incdir+design
design/align_ecc_pkg.sv
design/ecc_secded_enc.sv
design/ecc_cmd_stage.sv
design/sram_1rw_model.sv
design/ecc_read_stage.sv
design/align_ecc_1rw_top.sv
tb/tb_align_ecc_1rw.sv

// ==== tb/tb_align_ecc_1rw.sv ====
`timescale 1ns/100ps
`include "align_ecc_params.svh"

module tb_align_ecc_1rw
  import align_ecc_pkg::*;
();

  localparam logic [1:0] OP_IDLE = 2'd0;
  localparam logic [1:0] OP_WR   = 2'd1;
  localparam logic [1:0] OP_RD   = 2'd2;
  localparam logic [1:0] OP_BOTH = 2'd3;
  localparam int MAX_ROWS     = 64;
  localparam int READ_LATENCY = 4;
  localparam int DRAIN_LIMIT  = 40;

  typedef struct packed {
    data_t       data;
    logic        serr;
    logic        derr;
    padr_t       padr;
    logic [31:0] issue_cyc;
  } exp_t;

  logic  clk;
  logic  rst;
  logic  write;
  addr_t wr_adr;
  data_t din;
  code_t wr_flip;
  logic  read;
  addr_t rd_adr;
  logic  rd_vld;
  data_t rd_dout;
  logic  rd_serr;
  logic  rd_derr;
  padr_t rd_padr;

  // stimulus table, one row per cycle.
  logic [1:0] tab_op   [0:MAX_ROWS-1];
  addr_t      tab_addr [0:MAX_ROWS-1];
  data_t      tab_data [0:MAX_ROWS-1];
  code_t      tab_flip [0:MAX_ROWS-1];
  int         row_cnt;

  data_t shadow_data [0:`ALIGN_NUMADDR-1];
  code_t shadow_flip [0:`ALIGN_NUMADDR-1];
  exp_t  exp_q [$];

  int     cycle;
  int     checks;
  int     mismatches;
  int     other_errors;
  int     drain_wait;
  integer seed;

  align_ecc_1rw_top u_align_ecc_1rw_top (
    .clk     (clk),
    .rst     (rst),
    .write   (write),
    .wr_adr  (wr_adr),
    .din     (din),
    .wr_flip (wr_flip),
    .read    (read),
    .rd_adr  (rd_adr),
    .rd_vld  (rd_vld),
    .rd_dout (rd_dout),
    .rd_serr (rd_serr),
    .rd_derr (rd_derr),
    .rd_padr (rd_padr)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  function automatic int count_flips(input code_t flip);
    int n;
    n = 0;
    for (int i = 0; i < `ALIGN_MEMWDTH; i++) begin
      n = n + flip[i];
    end
    return n;
  endfunction

  task check_value(input string what, input logic [63:0] got, input logic [63:0] expv);
    checks++;
    if (got !== expv) begin
      mismatches++;
      $display("MISMATCH at time %0t: %s got %0h expected %0h", $time, what, got, expv);
    end
  endtask

  task add_row(input logic [1:0] op, input addr_t addr, input data_t data, input code_t flip);
    tab_op[row_cnt]   = op;
    tab_addr[row_cnt] = addr;
    tab_data[row_cnt] = data;
    tab_flip[row_cnt] = flip;
    row_cnt++;
  endtask

  // drives one row and predicts its read result from the shadow.
  task apply_row(input int idx);
    logic wr_acc;
    logic rd_acc;
    int   nflip;
    exp_t e;
    write   = tab_op[idx][0];
    read    = tab_op[idx][1];
    wr_adr  = tab_addr[idx];
    rd_adr  = tab_addr[idx];
    din     = tab_data[idx];
    wr_flip = tab_flip[idx];
    wr_acc  = write && (tab_addr[idx] < `ALIGN_NUMADDR);
    rd_acc  = read && !wr_acc && (tab_addr[idx] < `ALIGN_NUMADDR);
    if (wr_acc) begin
      shadow_data[tab_addr[idx]] = tab_data[idx];
      shadow_flip[tab_addr[idx]] = tab_flip[idx];
    end
    if (rd_acc) begin
      nflip  = count_flips(shadow_flip[tab_addr[idx]]);
      e.data = shadow_data[tab_addr[idx]];
      // a double error comes back uncorrected.
      if (nflip == 2) begin
        e.data = e.data ^ shadow_flip[tab_addr[idx]][`ALIGN_WIDTH-1:0];
      end
      e.serr      = (nflip == 1);
      e.derr      = (nflip == 2);
      e.padr      = {word_sel_t'(tab_addr[idx] % `ALIGN_NUMWRDS),
                     srow_t'(tab_addr[idx] / `ALIGN_NUMWRDS)};
      e.issue_cyc = cycle;
      exp_q.push_back(e);
    end
  endtask

  task build_table;
    row_cnt = 0;
    // plain write then read, including the top sub-row.
    add_row(OP_WR, 6'd0, 32'h1234_5678, '0);
    add_row(OP_WR, 6'd47, 32'hcafe_f00d, '0);
    add_row(OP_WR, 6'd45, 32'h0bad_c0de, '0);
    add_row(OP_WR, 6'd5, 32'ha5a5_5a5a, '0);
    add_row(OP_RD, 6'd5, '0, '0);
    add_row(OP_RD, 6'd0, '0, '0);
    add_row(OP_RD, 6'd47, '0, '0);
    add_row(OP_RD, 6'd45, '0, '0);
    // single flips in a data bit, a hamming bit and the parity bit.
    add_row(OP_WR, 6'd10, 32'h0000_ffff, code_t'(1) << 5);
    add_row(OP_WR, 6'd11, 32'hffff_0000, code_t'(1) << 34);
    add_row(OP_WR, 6'd12, 32'h1357_9bdf, code_t'(1) << 38);
    add_row(OP_RD, 6'd10, '0, '0);
    add_row(OP_RD, 6'd11, '0, '0);
    add_row(OP_RD, 6'd12, '0, '0);
    // double flips.
    add_row(OP_WR, 6'd13, 32'h2468_ace0, (code_t'(1) << 3) | (code_t'(1) << 20));
    add_row(OP_WR, 6'd14, 32'h8765_4321, (code_t'(1) << 7) | (code_t'(1) << 33));
    add_row(OP_RD, 6'd13, '0, '0);
    add_row(OP_RD, 6'd14, '0, '0);
    // all four words of row 5, read back to back.
    for (int i = 20; i < 24; i++) begin
      add_row(OP_WR, addr_t'(i), $random(seed), '0);
    end
    for (int i = 20; i < 24; i++) begin
      add_row(OP_RD, addr_t'(i), '0, '0);
    end
    // write wins over read, out of range commands do nothing.
    add_row(OP_BOTH, 6'd24, 32'h5555_aaaa, '0);
    add_row(OP_IDLE, 6'd0, '0, '0);
    add_row(OP_RD, 6'd24, '0, '0);
    add_row(OP_WR, 6'd48, 32'hdead_beef, '0);
    add_row(OP_BOTH, 6'd63, 32'hbeef_dead, '0);
    add_row(OP_RD, 6'd50, '0, '0);
    add_row(OP_RD, 6'd0, '0, '0);
    // read just before and just after a write to the same word.
    add_row(OP_WR, 6'd30, 32'h0101_0101, '0);
    add_row(OP_IDLE, 6'd0, '0, '0);
    add_row(OP_RD, 6'd30, '0, '0);
    add_row(OP_WR, 6'd30, 32'hfefe_fefe, '0);
    add_row(OP_RD, 6'd30, '0, '0);
    for (int i = 0; i < 8; i++) begin
      add_row(OP_IDLE, 6'd0, '0, '0);
    end
  endtask

  // outputs are sampled mid-cycle, well away from the clock edge.
  always @(negedge clk) begin : rd_monitor
    exp_t e;
    if (rd_vld === 1'b1) begin
      if (exp_q.size() == 0) begin
        other_errors++;
        $display("error at time %0t: rd_vld came with no read outstanding", $time);
      end else begin
        e = exp_q.pop_front();
        check_value("rd_dout", rd_dout, e.data);
        check_value("rd_serr", rd_serr, e.serr);
        check_value("rd_derr", rd_derr, e.derr);
        check_value("rd_padr", rd_padr, e.padr);
        check_value("read latency", cycle - e.issue_cyc, READ_LATENCY);
      end
    end
  end

  initial begin
    clk          = 1'b0;
    rst          = 1'b1;
    write        = 1'b0;
    read         = 1'b0;
    wr_adr       = '0;
    rd_adr       = '0;
    din          = '0;
    wr_flip      = '0;
    cycle        = 0;
    checks       = 0;
    mismatches   = 0;
    other_errors = 0;
    seed         = 32'h7aafadc5;
    build_table();
    repeat (3) @(posedge clk);
    #2;
    rst = 1'b0;
    for (int r = 0; r < row_cnt; r++) begin
      @(posedge clk);
      #2;
      apply_row(r);
    end
    drain_wait = 0;
    while (exp_q.size() != 0 && drain_wait < DRAIN_LIMIT) begin
      @(posedge clk);
      drain_wait++;
    end
    if (exp_q.size() != 0) begin
      other_errors++;
      $display("timeout: %0d reads never returned rd_vld", exp_q.size());
    end
    $display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule
